/* rtl/mem_ctrl_pkg.sv */
`default_nettype none

package mem_ctrl_pkg;

    // datapath geometry
    localparam int data_w = 64;
    localparam int addr_w = 32;

    // sequencer geometry, one block = 341 lines of 4 beats
    localparam int beats          = 4;
    localparam int square_lines   = 336;
    localparam int last_line      = 340;
    localparam int save_wen_line  = 339;
    localparam int state_off_line = 338;

    // hash ram holds A, secret ram holds S then the result tile
    localparam int a_stride       = 1344 * 16;
    localparam int se_stride      = 1344 * 8;
    localparam int half_offset    = 4 * se_stride;  // odd blocks use the upper secret half
    localparam int b_base         = 1344 * 64;
    localparam int hash_line_step = 64;
    localparam int sp_line_step   = 32;
    localparam int save_pair_step = 512;
    localparam int save_half_step = 64;
    localparam int save_row_step  = 128;

    typedef logic [2:0] mode_t;
    localparam mode_t as_mode = 3'd1;

    typedef enum logic [3:0] {
        st_free   = 4'd0,
        st_square = 4'd1,
        st_save   = 4'd2,
        st_wait   = 4'd3
    } seq_state_t;

    typedef logic [$clog2(beats)-1:0] beat_t;
    typedef logic [8:0]               line_t;
    typedef logic [9:0]               block_t;

endpackage

`default_nettype wire

/* rtl/seq_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface seq_if;
    import mem_ctrl_pkg::*;

    seq_state_t state;
    beat_t      beat;
    line_t      line;
    block_t     block;
    logic       step;   // high in the last wait cycle before a new block

    modport seq (output state, output beat, output line, output block, output step);

    // address side needs block for the secret half and save base
    modport addr (input state, input beat, input line, input block);

    modport feed (input state, input beat, input line, input step);

endinterface

`default_nettype wire

/* rtl/mat_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module mat_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     calc_init,
    input  mem_ctrl_pkg::mode_t      mem_mode,
    input  logic                     hash_ready,
    output logic                     systolic_mode,
    output mem_ctrl_pkg::seq_state_t current_state,
    seq_if.seq                       seq
);
    import mem_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    mode_t      mode;
    beat_t      beat;
    line_t      line;
    block_t     block;
    logic       computing;
    logic       beat_last;
    logic       square_done;
    logic       save_done;
    logic       restart;

    assign computing   = (state == st_square) || (state == st_save);
    assign beat_last   = (beat == beat_t'(beats - 1));
    assign square_done = beat_last && (line == line_t'(square_lines - 1));
    assign save_done   = beat_last && (line == line_t'(last_line));
    assign restart     = (state == st_wait) && hash_ready;  // level handshake

    always_comb begin
        next_state = state;
        case (state)
            st_free: begin
                if (mode == as_mode) begin
                    next_state = st_square;
                end
            end
            st_square: begin
                if (square_done) begin
                    next_state = st_save;
                end
            end
            st_save: begin
                if (save_done) begin
                    next_state = st_wait;
                end
            end
            st_wait: begin
                if (hash_ready) begin
                    next_state = st_square;
                end
            end
            default: next_state = st_free;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_free;
            mode          <= '0;
            systolic_mode <= 1'b0;
        end else begin
            if (calc_init) begin
                state <= st_free;     // new request always restarts from idle
                mode  <= mem_mode;
            end else begin
                state <= next_state;
            end
            systolic_mode <= (mode == as_mode);
        end
    end

    // beat and line only run while computing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
            line <= '0;
        end else if (calc_init || restart) begin
            beat <= '0;
            line <= '0;
        end else if (computing) begin
            beat <= beat + 1'b1;
            if (beat_last) begin
                line <= (line == line_t'(last_line)) ? '0 : line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block <= '0;
        end else if (calc_init) begin
            block <= '0;
        end else if (state == st_save && save_done) begin
            block <= block + 1'b1;  // moves secret half and save base
        end
    end

    assign seq.state     = state;
    assign seq.beat      = beat;
    assign seq.line      = line;
    assign seq.block     = block;
    assign seq.step      = restart;
    assign current_state = state;

endmodule

`default_nettype wire

/* rtl/addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
    seq_if.addr                              pos,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_sp,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_hash,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp_2,
    output logic                             wen_sp_2,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_adder
);
    import mem_ctrl_pkg::*;

    logic [addr_w-1:0] half_base;
    logic [addr_w-1:0] save_base;
    beat_t             row_rd;
    beat_t             row_wr;

    assign half_base = pos.block[0] ? addr_w'(half_offset) : '0;

    // result tile base, two blocks per pair of row groups
    assign save_base = addr_w'(b_base)
                     + addr_w'(pos.block >> 1) * save_pair_step
                     + (pos.block[0] ? addr_w'(save_half_step) : '0);

    assign row_rd = beat_t'(2) - pos.beat;
    assign row_wr = row_rd + beat_t'(2);   // write lags read by two rows

    always_comb begin
        addr_hash  = '0;
        addr_sp    = '0;
        addr_sp_2  = '0;
        wen_sp_2   = 1'b0;
        data_adder = '0;
        case (pos.state)
            st_square: begin
                addr_hash = addr_w'(pos.line) * hash_line_step
                          + addr_w'(pos.beat) * a_stride;
                addr_sp   = addr_w'(pos.line) * sp_line_step
                          + addr_w'(pos.beat) * se_stride + half_base;
            end
            st_save: begin
                addr_hash  = addr_w'(1);
                addr_sp    = save_base + addr_w'(row_rd) * save_row_step;
                addr_sp_2  = save_base + addr_w'(row_wr) * save_row_step;
                data_adder = bram_data_sp;
                // four beat burst straddling the last two lines
                wen_sp_2   = (pos.line == line_t'(save_wen_line) && pos.beat != '0)
                          || (pos.line == line_t'(last_line) && pos.beat == '0);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/systolic_feed.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_feed (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             calc_init,
    seq_if.feed                              pos,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_hash,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_sp,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_left,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_right,
    output logic                             systolic_enable,
    output logic                             systolic_state,
    output logic                             transposition_select,
    output logic                             transposition_rst_sync
);
    import mem_ctrl_pkg::*;

    logic squaring;
    logic saving;
    logic beat_last;
    logic enable_d;
    logic state_d;

    assign squaring  = (pos.state == st_square);
    assign saving    = (pos.state == st_save);
    assign beat_last = (pos.beat == beat_t'(beats - 1));

    // operands only flow during the product phase
    assign data_left  = squaring ? bram_data_hash : '0;
    assign data_right = squaring ? bram_data_sp : '0;

    // array keeps running while the tile drains out
    assign enable_d = squaring
                   || (saving && !(beat_last && pos.line == line_t'(last_line)));

    // compute flag drops after line 338
    assign state_d = squaring
                  || (saving && (pos.line < line_t'(state_off_line)
                  || (pos.line == line_t'(state_off_line) && !beat_last)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            systolic_enable <= 1'b0;
            systolic_state  <= 1'b0;
        end else begin
            systolic_enable <= enable_d;
            systolic_state  <= state_d;
        end
    end

    // ping-pong transposer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transposition_select   <= 1'b1;
            transposition_rst_sync <= 1'b0;
        end else begin
            transposition_rst_sync <= pos.step;  // first cycle of the new block
            if (calc_init || pos.step) begin
                transposition_select <= 1'b1;
            end else if ((squaring || saving) && pos.beat == '0) begin
                transposition_select <= ~transposition_select;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  mem_ctrl_pkg::mode_t              mem_mode,
    input  logic                             calc_init,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_sp,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_hash,
    input  logic                             hash_ready,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_left,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_right,
    output logic [mem_ctrl_pkg::data_w-1:0]  data_adder,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp_2,
    output logic [mem_ctrl_pkg::addr_w-1:0]  addr_hash,
    output logic                             wen_sp_2,
    output logic                             systolic_mode,
    output logic                             systolic_enable,
    output logic                             systolic_state,
    output logic                             transposition_select,
    output logic                             transposition_rst_sync,
    output mem_ctrl_pkg::seq_state_t         current_state
);

    seq_if i_seq_if ();

    mat_seq i_mat_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .calc_init     (calc_init),
        .mem_mode      (mem_mode),
        .hash_ready    (hash_ready),
        .systolic_mode (systolic_mode),
        .current_state (current_state),
        .seq           (i_seq_if.seq)
    );

    addr_gen i_addr_gen (
        .pos          (i_seq_if.addr),
        .bram_data_sp (bram_data_sp),
        .addr_hash    (addr_hash),
        .addr_sp      (addr_sp),
        .addr_sp_2    (addr_sp_2),
        .wen_sp_2     (wen_sp_2),
        .data_adder   (data_adder)
    );

    systolic_feed i_systolic_feed (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .calc_init              (calc_init),
        .pos                    (i_seq_if.feed),
        .bram_data_hash         (bram_data_hash),
        .bram_data_sp           (bram_data_sp),
        .data_left              (data_left),
        .data_right             (data_right),
        .systolic_enable        (systolic_enable),
        .systolic_state         (systolic_state),
        .transposition_select   (transposition_select),
        .transposition_rst_sync (transposition_rst_sync)
    );

endmodule

`default_nettype wire

/* tests/mem_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             calc_init,
    input  logic [2:0]                       mem_mode,
    input  logic                             hash_ready,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_sp,
    input  logic [mem_ctrl_pkg::data_w-1:0]  bram_data_hash,
    input  logic [mem_ctrl_pkg::data_w-1:0]  data_left,
    input  logic [mem_ctrl_pkg::data_w-1:0]  data_right,
    input  logic [mem_ctrl_pkg::data_w-1:0]  data_adder,
    input  logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp,
    input  logic [mem_ctrl_pkg::addr_w-1:0]  addr_sp_2,
    input  logic [mem_ctrl_pkg::addr_w-1:0]  addr_hash,
    input  logic                             wen_sp_2,
    input  logic                             systolic_mode,
    input  logic                             systolic_enable,
    input  logic                             systolic_state,
    input  logic                             transposition_select,
    input  logic                             transposition_rst_sync,
    input  mem_ctrl_pkg::seq_state_t         current_state,
    input  logic                             expect_valid,
    input  mem_ctrl_pkg::seq_state_t         expect_state,
    output int                               mismatch_count,
    output int                               fault_count
);
    import mem_ctrl_pkg::*;

    localparam int block_cycles  = (last_line + 1) * beats;     // 1364
    localparam int square_cycles = square_lines * beats;
    localparam int state_off_pos = state_off_line * beats + beats - 1;

    int         mismatches = 0;
    int         faults = 0;
    seq_state_t exp_state;
    int         pos;    // cycle inside the block
    int         blk;
    mode_t      mode_q;
    logic       exp_mode;
    logic       exp_enable;
    logic       exp_sflag;
    logic       exp_tsel;
    logic       exp_trst;
    logic       ready_seen;

    assign mismatch_count = mismatches;
    assign fault_count    = faults;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin
        logic [63:0] e_left;
        logic [63:0] e_right;
        logic [63:0] e_adder;
        logic [63:0] e_sp;
        logic [63:0] e_sp2;
        logic [63:0] e_hash;
        logic        e_wen;
        logic        running;
        int          line;
        int          beat;
        int          base;
        if (!rst_n) begin
            exp_state  = st_free;
            pos        = 0;
            blk        = 0;
            mode_q     = '0;
            exp_mode   = 1'b0;
            exp_enable = 1'b0;
            exp_sflag  = 1'b0;
            exp_tsel   = 1'b1;
            exp_trst   = 1'b0;
            ready_seen = 1'b0;
        end else begin
            line    = pos / beats;
            beat    = pos % beats;
            base    = b_base + (blk / 2) * save_pair_step + (blk % 2) * save_half_step;
            e_left  = '0;
            e_right = '0;
            e_adder = '0;
            e_sp    = '0;
            e_sp2   = '0;
            e_hash  = '0;
            e_wen   = 1'b0;
            if (exp_state == st_square) begin
                e_left  = bram_data_hash;
                e_right = bram_data_sp;
                e_hash  = 64'(line * hash_line_step + beat * a_stride);
                e_sp    = 64'(line * sp_line_step + beat * se_stride
                        + ((blk % 2 == 1) ? half_offset : 0));
            end else if (exp_state == st_save) begin
                e_adder = bram_data_sp;
                e_hash  = 64'd1;
                e_sp    = 64'(base + ((6 - beat) % beats) * save_row_step);  // rows 2,1,0,3
                e_sp2   = 64'(base + ((4 - beat) % beats) * save_row_step);
                e_wen   = (line == save_wen_line && beat != 0) || (line == last_line && beat == 0);
            end
            if (ready_seen && current_state == st_wait) begin
                faults++;
                $display("ERROR: sequencer stayed in the wait state after hash_ready at %0t",
                         $time);
            end
            if (expect_valid) begin
                compare_value("current_state after start", 64'(current_state), 64'(expect_state));
            end
            compare_value("current_state", 64'(current_state), 64'(exp_state));
            compare_value("data_left", data_left, e_left);
            compare_value("data_right", data_right, e_right);
            compare_value("data_adder", data_adder, e_adder);
            compare_value("addr_hash", 64'(addr_hash), e_hash);
            compare_value("addr_sp", 64'(addr_sp), e_sp);
            compare_value("addr_sp_2", 64'(addr_sp_2), e_sp2);
            compare_value("wen_sp_2", 64'(wen_sp_2), 64'(e_wen));
            compare_value("systolic_mode", 64'(systolic_mode), 64'(exp_mode));
            compare_value("systolic_enable", 64'(systolic_enable), 64'(exp_enable));
            compare_value("systolic_state", 64'(systolic_state), 64'(exp_sflag));
            compare_value("transposition_select", 64'(transposition_select), 64'(exp_tsel));
            compare_value("transposition_rst_sync", 64'(transposition_rst_sync),
                          64'(exp_trst));

            // flags one edge behind the position that causes them
            running    = (exp_state == st_square) || (exp_state == st_save);
            ready_seen = (exp_state == st_wait) && hash_ready;
            exp_trst   = ready_seen;
            exp_mode   = (mode_q == as_mode);
            exp_enable = running && (pos != block_cycles - 1);
            exp_sflag  = running && (pos < state_off_pos);
            if (calc_init || ready_seen) begin
                exp_tsel = 1'b1;
            end else if (running && beat == 0) begin
                exp_tsel = ~exp_tsel;
            end
            if (calc_init) begin
                exp_state = st_free;
                pos       = 0;
                blk       = 0;
                mode_q    = mem_mode;
            end else if (exp_state == st_free) begin
                if (mode_q == as_mode) exp_state = st_square;
            end else if (ready_seen) begin
                exp_state = st_square;
            end else if (running) begin
                if (pos == block_cycles - 1) begin
                    exp_state = st_wait;
                    pos       = 0;
                    blk++;
                end else begin
                    pos++;
                    exp_state = (pos < square_cycles) ? st_square : st_save;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;
    import mem_ctrl_pkg::*;

    localparam int period       = 8;
    localparam int reset_cycles = 4;
    localparam int idle_cycles  = 20;
    localparam int block_cycles = (last_line + 1) * beats;
    localparam int n_cases      = 3;

    // mode, blocks, hash_ready delay, expected state two edges after calc_init
    typedef struct packed {
        logic [2:0] mode;
        int         blocks;
        int         delay;
        seq_state_t exp_state;
    } case_t;

    localparam case_t cases [n_cases] = '{
        '{3'd5, 0, 0, st_free},     // ignored mode
        '{as_mode, 3, 5, st_square},
        '{as_mode, 2, 0, st_square}
    };

    logic              clk = 1'b0;
    logic              rst_n;
    logic [2:0]        mem_mode;
    logic              calc_init;
    logic              hash_ready;
    logic [data_w-1:0] bram_data_sp;
    logic [data_w-1:0] bram_data_hash;
    logic [data_w-1:0] data_left;
    logic [data_w-1:0] data_right;
    logic [data_w-1:0] data_adder;
    logic [addr_w-1:0] addr_sp;
    logic [addr_w-1:0] addr_sp_2;
    logic [addr_w-1:0] addr_hash;
    logic              wen_sp_2;
    logic              systolic_mode;
    logic              systolic_enable;
    logic              systolic_state;
    logic              transposition_select;
    logic              transposition_rst_sync;
    seq_state_t        current_state;
    logic              expect_valid;
    seq_state_t        expect_state;
    int                mismatch_count;
    int                fault_count;
    int                tb_faults = 0;

    always #(period / 2) clk = ~clk;

    mem_ctrl i_mem_ctrl (.*);

    mem_ctrl_checker i_checker (.*);

    // fresh ram words every cycle
    always @(posedge clk) begin
        #1;
        bram_data_sp   = {$urandom(), $urandom()};
        bram_data_hash = {$urandom(), $urandom()};
    end

    function automatic int budget_cycles();
        int total;
        total = reset_cycles + idle_cycles;
        for (int i = 0; i < n_cases; i++) begin
            total += idle_cycles + cases[i].blocks * (block_cycles + cases[i].delay + 4);
        end
        return total + 200;
    endfunction

    task automatic wait_for_wait_state(output bit reached);
        int n;
        n       = 0;
        reached = 1'b0;
        while (!reached && n < block_cycles + 20) begin
            @(posedge clk);
            #1;
            reached = (current_state == st_wait);
            n++;
        end
    endtask

    task automatic run_case(input case_t c);
        bit reached;
        @(posedge clk);
        #1;
        mem_mode  = c.mode;
        calc_init = 1'b1;
        @(posedge clk);
        #1 calc_init = 1'b0;
        @(posedge clk);
        #1;
        expect_state = c.exp_state;
        expect_valid = 1'b1;
        @(posedge clk);
        #1 expect_valid = 1'b0;
        if (c.blocks == 0) begin
            repeat (idle_cycles) @(posedge clk);
        end
        for (int b = 0; b < c.blocks; b++) begin
            wait_for_wait_state(reached);
            if (!reached) begin
                tb_faults++;
                $display("ERROR: sequencer never reached the wait state in block %0d", b);
                return;
            end
            if (b < c.blocks - 1) begin
                repeat (c.delay) begin
                    @(posedge clk);
                    #1;
                end
                hash_ready = 1'b1;
                @(posedge clk);
                #1 hash_ready = 1'b0;
            end
        end
    endtask

    initial begin
        #(budget_cycles() * period);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        mem_mode       = '0;
        calc_init      = 1'b0;
        hash_ready     = 1'b0;
        bram_data_sp   = '0;
        bram_data_hash = '0;
        expect_valid   = 1'b0;
        expect_state   = st_free;
        void'($urandom(32'h9263_1b13));
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (idle_cycles) @(posedge clk);
        for (int i = 0; i < n_cases; i++) begin
            run_case(cases[i]);
        end
        repeat (10) @(posedge clk);     // wait state holds with hash_ready low
        #1;
        $display("error counts: %0d mismatches, %0d other failures",
                 mismatch_count, fault_count + tb_faults);
        if (mismatch_count == 0 && fault_count == 0 && tb_faults == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/mem_ctrl_pkg.sv
rtl/seq_if.sv
rtl/mat_seq.sv
rtl/addr_gen.sv
rtl/systolic_feed.sv
rtl/mem_ctrl.sv
tests/mem_ctrl_checker.sv
tests/tb_mem_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the mem_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --top-module tb_mem_ctrl -f compile.f -o sim_mem_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_mem_ctrl > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
